//--- byte_serializer.sv
`timescale 1ns/1ps

module byte_serializer (
    input  logic                adc_sampleclk,
    input  logic                reset,
    input  logic                arm_i,
    input  logic                read_en_i,
    input  logic                low_res_i,
    input  logic                low_res_lsb_i,
    input  capture_pkg::word_t  head_word_i,
    input  logic                fifo_empty_i,
    output logic [7:0]          byte_o,
    output logic                pop_o,
    output logic                underflow_err_o
);

    logic [3:0]           pos;      // byte position, 0..2 low-res, 0..8 high-res
    logic [3:0]           nibble;   // low nibble of the first high-res word
    capture_pkg::sample_t sel_sample;
    logic [7:0]           low_byte;
    logic [7:0]           high_byte;
    logic                 read_ok;

    // nothing is consumed once underflow is flagged
    assign read_ok = read_en_i && !fifo_empty_i && !underflow_err_o;

    assign pop_o = read_ok && (low_res_i ? (pos == 4'(capture_pkg::WORD_SAMPLES - 1))
                                         : (pos == 4'd3 || pos == 4'd8));

    always_comb begin
        case (pos)
            4'd0:    sel_sample = head_word_i[35:24];   // oldest sample
            4'd1:    sel_sample = head_word_i[23:12];
            4'd2:    sel_sample = head_word_i[11:0];
            default: sel_sample = '0;
        endcase
    end

    assign low_byte = low_res_lsb_i ? sel_sample[7:0] : sel_sample[11:4];

    // two words as one 72-bit stream, msb first
    always_comb begin
        case (pos)
            4'd0:    high_byte = head_word_i[35:28];
            4'd1:    high_byte = head_word_i[27:20];
            4'd2:    high_byte = head_word_i[19:12];
            4'd3:    high_byte = head_word_i[11:4];
            4'd4:    high_byte = {nibble, head_word_i[35:32]};   // straddles both words
            4'd5:    high_byte = head_word_i[31:24];
            4'd6:    high_byte = head_word_i[23:16];
            4'd7:    high_byte = head_word_i[15:8];
            4'd8:    high_byte = head_word_i[7:0];
            default: high_byte = 8'h00;
        endcase
    end

    assign byte_o = (underflow_err_o || fifo_empty_i) ? 8'h00
                  : (low_res_i ? low_byte : high_byte);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            pos <= '0;
        end else if (arm_i) begin
            pos <= '0;
        end else if (read_ok) begin
            if (low_res_i)
                pos <= (pos >= 4'(capture_pkg::WORD_SAMPLES - 1)) ? 4'd0 : pos + 4'd1;
            else
                pos <= (pos == 4'd8) ? 4'd0 : pos + 4'd1;
        end
    end

    // kept before the first word is popped
    always_ff @(posedge adc_sampleclk) begin
        if (read_ok && !low_res_i && pos == 4'd3)
            nibble <= head_word_i[3:0];
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            underflow_err_o <= 1'b0;
        else if (arm_i)
            underflow_err_o <= 1'b0;
        else if (read_en_i && fifo_empty_i)
            underflow_err_o <= 1'b1;   // host read with nothing buffered
    end

endmodule

//--- capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl (
    input  logic                  adc_sampleclk,
    input  logic                  reset,
    input  logic                  arm_i,
    input  logic                  capture_go_i,
    input  capture_pkg::sample_t  adc_data_i,
    input  capture_pkg::skip_t    downsample_i,
    input  capture_pkg::count_t   num_samples_i,
    input  logic                  no_clip_errors_i,
    input  logic                  credit_ret_i,
    output logic                  wr_valid_o,
    output capture_pkg::word_t    wr_word_o,
    output logic                  capture_stop_o,
    output logic                  clip_err_o,
    output logic                  overflow_err_o
);

    capture_pkg::capture_state_t state;
    capture_pkg::skip_t          ds_cnt;
    capture_pkg::count_t         sample_cnt;
    capture_pkg::credit_t        credits;
    capture_pkg::word_t          pack;
    logic [1:0]                  slot;          // slot of the next sample in the word
    logic [capture_pkg::COUNT_W:0] taken_next;  // one bit wider, no wrap on compare

    logic arm_ok;
    logic take;
    logic word_end;
    logic last_sample;
    logic has_credit;
    logic clipped;

    assign arm_ok = arm_i && (state == capture_pkg::CAP_IDLE || state == capture_pkg::CAP_DONE);
    assign take = (state == capture_pkg::CAP_RUN) && (ds_cnt == downsample_i);
    assign word_end = take && (slot == 2'(capture_pkg::WORD_SAMPLES - 1));
    assign taken_next = {1'b0, sample_cnt} + 1'b1;

    // stop at the first word boundary at or past the requested count
    assign last_sample = word_end && (taken_next >= {1'b0, num_samples_i});
    assign has_credit = (credits != '0);
    assign clipped = take && !no_clip_errors_i && (adc_data_i == '1 || adc_data_i == '0);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state          <= capture_pkg::CAP_IDLE;
            ds_cnt         <= '0;
            slot           <= '0;
            sample_cnt     <= '0;
            capture_stop_o <= 1'b0;
        end else begin
            case (state)
                capture_pkg::CAP_IDLE: begin
                    if (arm_i)
                        state <= capture_pkg::CAP_ARMED;
                end
                capture_pkg::CAP_ARMED: begin
                    if (capture_go_i) begin
                        state      <= capture_pkg::CAP_RUN;
                        ds_cnt     <= '0;
                        slot       <= '0;
                        sample_cnt <= '0;
                    end
                end
                capture_pkg::CAP_RUN: begin
                    if (take) begin
                        ds_cnt     <= '0;
                        sample_cnt <= taken_next[capture_pkg::COUNT_W-1:0];
                        slot       <= word_end ? 2'd0 : slot + 2'd1;
                        if (last_sample)
                            state <= capture_pkg::CAP_DONE;
                    end else begin
                        ds_cnt <= ds_cnt + 1'b1;
                    end
                end
                capture_pkg::CAP_DONE: begin
                    if (arm_i) begin
                        state          <= capture_pkg::CAP_ARMED;
                        capture_stop_o <= 1'b0;
                    end else begin
                        capture_stop_o <= 1'b1;   // one cycle after the last write slot
                    end
                end
                default: state <= capture_pkg::CAP_IDLE;
            endcase
        end
    end

    // newest sample enters at the bottom
    always_ff @(posedge adc_sampleclk) begin
        if (take)
            pack <= {pack[capture_pkg::WORD_W-capture_pkg::SAMPLE_W-1:0], adc_data_i};
    end

    assign wr_word_o = pack;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_valid_o <= 1'b0;
            credits    <= capture_pkg::credit_t'(capture_pkg::FIFO_DEPTH);
        end else begin
            wr_valid_o <= word_end && has_credit;
            credits    <= credits + capture_pkg::credit_t'(credit_ret_i)
                        - capture_pkg::credit_t'(word_end && has_credit);
        end
    end

    // sticky errors, cleared when a new capture is armed
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            clip_err_o     <= 1'b0;
            overflow_err_o <= 1'b0;
        end else if (arm_ok) begin
            clip_err_o     <= 1'b0;
            overflow_err_o <= 1'b0;
        end else begin
            if (clipped)
                clip_err_o <= 1'b1;
            if (word_end && !has_credit)
                overflow_err_o <= 1'b1;   // adc cannot stall, word is lost
        end
    end

endmodule

//--- capture_pkg.sv
package capture_pkg;

    // sample and word geometry
    localparam int SAMPLE_W     = 12;
    localparam int WORD_SAMPLES = 3;
    localparam int WORD_W       = 36;    // WORD_SAMPLES * SAMPLE_W

    // word buffer, power of two so the pointers wrap by themselves
    localparam int FIFO_DEPTH = 16;
    localparam int CREDIT_W   = 5;       // holds 0 .. FIFO_DEPTH

    // capture settings
    localparam int DOWNSAMPLE_W = 13;
    localparam int COUNT_W      = 20;

    // one raw ADC sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // three samples, oldest in bits 35:24
    typedef logic [WORD_W-1:0] word_t;

    // producer credit counter
    typedef logic [CREDIT_W-1:0] credit_t;

    // samples to skip between taken samples
    typedef logic [DOWNSAMPLE_W-1:0] skip_t;

    // requested and taken sample counts
    typedef logic [COUNT_W-1:0] count_t;

    // capture sequencing
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARMED,
        CAP_RUN,
        CAP_DONE
    } capture_state_t;

endpackage

//--- capture_top.sv
`timescale 1ns/1ps

module capture_top (
    input  logic                  adc_sampleclk,
    input  logic                  reset,
    input  logic                  arm_i,
    input  logic                  capture_go_i,
    input  capture_pkg::sample_t  adc_data_i,
    input  capture_pkg::skip_t    downsample_i,
    input  capture_pkg::count_t   num_samples_i,
    input  logic                  no_clip_errors_i,
    input  logic                  read_en_i,
    input  logic                  low_res_i,
    input  logic                  low_res_lsb_i,
    output logic                  capture_stop_o,
    output logic                  empty_o,
    output logic [7:0]            byte_o,
    output logic                  error_o,
    output logic [2:0]            error_stat_o
);

    logic               wr_valid;
    capture_pkg::word_t wr_word;
    logic               credit_ret;
    capture_pkg::word_t head_word;
    logic               fifo_empty;
    logic               pop;
    logic               clip_err;
    logic               overflow_err;
    logic               underflow_err;

    capture_ctrl u_capture_ctrl (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .adc_data_i       (adc_data_i),
        .downsample_i     (downsample_i),
        .num_samples_i    (num_samples_i),
        .no_clip_errors_i (no_clip_errors_i),
        .credit_ret_i     (credit_ret),
        .wr_valid_o       (wr_valid),
        .wr_word_o        (wr_word),
        .capture_stop_o   (capture_stop_o),
        .clip_err_o       (clip_err),
        .overflow_err_o   (overflow_err)
    );

    word_fifo u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_valid_i    (wr_valid),
        .wr_word_i     (wr_word),
        .pop_i         (pop),
        .head_word_o   (head_word),
        .empty_o       (fifo_empty),
        .credit_ret_o  (credit_ret)
    );

    byte_serializer u_byte_serializer (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .read_en_i       (read_en_i),
        .low_res_i       (low_res_i),
        .low_res_lsb_i   (low_res_lsb_i),
        .head_word_i     (head_word),
        .fifo_empty_i    (fifo_empty),
        .byte_o          (byte_o),
        .pop_o           (pop),
        .underflow_err_o (underflow_err)
    );

    assign empty_o      = fifo_empty;
    assign error_stat_o = {clip_err, overflow_err, underflow_err};   // clip is bit 2
    assign error_o      = |error_stat_o;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_capture -f vlog.f -o tb_capture
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_capture 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

//--- tb_capture.sv
`timescale 1ns/1ps

module tb_capture;

    localparam int CAP_OVH     = 8;   // arm, go, stop wait and slack per capture
    localparam int TEST_CYCLES = 10 + 2 + 2 * (CAP_OVH + 9 + 9) + (CAP_OVH + 6 + 9)
                               + (CAP_OVH + 4 * 9 + 9) + (CAP_OVH + 60 + 48)
                               + 2 * (CAP_OVH + 3 + 3) + 3;
    localparam int WATCHDOG_NS = 4 * 100 * TEST_CYCLES;

    logic                 adc_sampleclk;
    logic                 reset;
    logic                 arm_i;
    logic                 capture_go_i;
    capture_pkg::sample_t adc_data_i;
    capture_pkg::skip_t   downsample_i;
    capture_pkg::count_t  num_samples_i;
    logic                 no_clip_errors_i;
    logic                 read_en_i;
    logic                 low_res_i;
    logic                 low_res_lsb_i;
    logic                 capture_stop_o;
    logic                 empty_o;
    logic [7:0]           byte_o;
    logic                 error_o;
    logic [2:0]           error_stat_o;

    capture_pkg::sample_t samples[$];   // taken samples of the current capture
    logic [15:0]          lfsr_state;
    int                   rd_idx;
    logic                 expect_zero;
    logic [7:0]           exp_byte;

    capture_top u_dut (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .adc_data_i       (adc_data_i),
        .downsample_i     (downsample_i),
        .num_samples_i    (num_samples_i),
        .no_clip_errors_i (no_clip_errors_i),
        .read_en_i        (read_en_i),
        .low_res_i        (low_res_i),
        .low_res_lsb_i    (low_res_lsb_i),
        .capture_stop_o   (capture_stop_o),
        .empty_o          (empty_o),
        .byte_o           (byte_o),
        .error_o          (error_o),
        .error_stat_o     (error_stat_o)
    );

    always #50 adc_sampleclk = ~adc_sampleclk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per sample bit
    task automatic next_sample(output capture_pkg::sample_t smp);
        smp = '0;
        for (int i = 0; i < 12; i++) begin
            smp        = {smp[10:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // byte idx of the readout stream
    function automatic logic [7:0] expected_byte(input int idx, input logic lr, input logic lsb);
        logic [71:0] bits;
        int          p;
        int          b;
        if (lr)
            return lsb ? samples[idx][7:0] : samples[idx][11:4];
        p    = (idx / 9) * 6;   // first sample of the word pair
        b    = idx % 9;
        bits = {samples[p], samples[p+1], samples[p+2],
                samples[p+3], samples[p+4], samples[p+5]};
        return bits[71 - 8 * b -: 8];
    endfunction

    function automatic logic expected_clip(input logic masked);
        logic hit;
        hit = 1'b0;
        foreach (samples[i])
            if (samples[i] == 12'hfff || samples[i] == 12'h000)
                hit = 1'b1;
        return hit && !masked;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_status(input logic [2:0] exp);
        assert (error_stat_o == exp)
        else report_mismatch("error_stat_o", 32'(exp), 32'(error_stat_o));
        // any sticky error raises the summary flag
        assert (error_o == |exp)
        else report_mismatch("error_o", 32'(|exp), 32'(error_o));
    endtask

    // every host read is checked against the reference at the clock edge
    always @(posedge adc_sampleclk) begin
        if (read_en_i) begin
            exp_byte = expect_zero ? 8'h00 : expected_byte(rd_idx, low_res_i, low_res_lsb_i);
            assert (byte_o == exp_byte)
            else report_mismatch("byte_o", 32'(exp_byte), 32'(byte_o));
            rd_idx = rd_idx + 1;
        end
    end

    task automatic run_capture(input int ds, input int num, input logic force_clip);
        int                   n_pad;
        int                   cnt;
        int                   guard;
        capture_pkg::sample_t smp;
        n_pad = (num < 3) ? 3 : ((num + 2) / 3) * 3;
        samples.delete();
        downsample_i  = 13'(ds);
        num_samples_i = 20'(num);
        arm_i         = 1'b1;
        @(negedge adc_sampleclk);
        arm_i        = 1'b0;
        capture_go_i = 1'b1;
        check_status(3'b000);   // arm clears all sticky bits
        assert (!capture_stop_o) else report_failure("capture_stop_o still high after arm");
        @(negedge adc_sampleclk);
        capture_go_i = 1'b0;
        cnt          = 0;
        while (samples.size() < n_pad) begin
            next_sample(smp);
            if (force_clip && samples.size() == 0)
                smp = 12'hfff;
            adc_data_i = smp;
            if (cnt == ds) begin
                samples.push_back(smp);
                cnt = 0;
            end else begin
                cnt++;
            end
            @(negedge adc_sampleclk);
        end
        guard = 0;
        while (!capture_stop_o && guard < 8) begin
            guard++;
            @(negedge adc_sampleclk);
        end
        assert (capture_stop_o) else report_failure("capture_stop_o did not rise after capture");
    endtask

    task automatic read_all(input logic lr, input logic lsb, input int n_exp);
        int guard;
        low_res_i     = lr;
        low_res_lsb_i = lsb;
        expect_zero   = 1'b0;
        rd_idx        = 0;
        guard         = 0;
        while (!empty_o && guard < 64) begin
            read_en_i = 1'b1;
            guard++;
            @(negedge adc_sampleclk);
        end
        read_en_i = 1'b0;
        assert (rd_idx == n_exp) else report_mismatch("read count", 32'(n_exp), 32'(rd_idx));
        assert (empty_o) else report_failure("buffer not empty after the expected reads");
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("run did not finish in time, watchdog expired");
    end

    initial begin
        adc_sampleclk    = 1'b0;
        reset            = 1'b1;
        arm_i            = 1'b0;
        capture_go_i     = 1'b0;
        adc_data_i       = '0;
        downsample_i     = '0;
        num_samples_i    = '0;
        no_clip_errors_i = 1'b0;
        read_en_i        = 1'b0;
        low_res_i        = 1'b1;
        low_res_lsb_i    = 1'b0;
        lfsr_state       = 16'd13254;
        rd_idx           = 0;
        expect_zero      = 1'b0;
        repeat (10) @(negedge adc_sampleclk);
        reset = 1'b0;
        @(negedge adc_sampleclk);
        check_status(3'b000);
        assert (empty_o && !capture_stop_o && !error_o)
        else report_failure("outputs not in reset state");

        run_capture(0, 7, 1'b0);   // padded to 9
        check_status({expected_clip(1'b0), 2'b00});
        read_all(1'b1, 1'b0, 9);
        run_capture(0, 7, 1'b0);
        check_status({expected_clip(1'b0), 2'b00});
        read_all(1'b1, 1'b1, 9);

        run_capture(0, 6, 1'b0);   // two words, high-res
        check_status({expected_clip(1'b0), 2'b00});
        read_all(1'b0, 1'b0, 9);

        run_capture(3, 9, 1'b0);
        check_status({expected_clip(1'b0), 2'b00});
        read_all(1'b1, 1'b0, 9);

        // 20 words against 16 credits
        run_capture(0, 60, 1'b0);
        check_status({expected_clip(1'b0), 2'b10});
        read_all(1'b1, 1'b0, 48);

        run_capture(0, 3, 1'b1);
        check_status(3'b100);
        read_all(1'b1, 1'b0, 3);

        // reads past empty
        expect_zero = 1'b1;
        repeat (3) begin
            read_en_i = 1'b1;
            @(negedge adc_sampleclk);
        end
        read_en_i = 1'b0;
        assert (empty_o) else report_failure("buffer left empty state after reads past empty");
        check_status(3'b101);

        no_clip_errors_i = 1'b1;
        run_capture(0, 3, 1'b1);
        check_status({expected_clip(1'b1), 2'b00});
        read_all(1'b1, 1'b0, 3);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- vlog.f
capture_pkg.sv
capture_ctrl.sv
word_fifo.sv
byte_serializer.sv
capture_top.sv
tb_capture.sv

//--- word_fifo.sv
`timescale 1ns/1ps

module word_fifo (
    input  logic                adc_sampleclk,
    input  logic                reset,
    input  logic                wr_valid_i,
    input  capture_pkg::word_t  wr_word_i,
    input  logic                pop_i,
    output capture_pkg::word_t  head_word_o,
    output logic                empty_o,
    output logic                credit_ret_o
);

    capture_pkg::word_t mem [capture_pkg::FIFO_DEPTH];

    logic [$clog2(capture_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(capture_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    capture_pkg::credit_t                       count;   // words held
    logic                                       pop_ok;

    assign empty_o = (count == '0);
    assign pop_ok = pop_i && !empty_o;

    // head is read straight from the array, a write shows up one cycle later
    assign head_word_o = mem[rd_ptr];

    always_ff @(posedge adc_sampleclk) begin
        if (wr_valid_i)
            mem[wr_ptr] <= wr_word_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credit_ret_o <= 1'b0;
        end else begin
            if (wr_valid_i)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at FIFO_DEPTH
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;

            // simultaneous write and pop leaves the count alone
            count <= count + capture_pkg::credit_t'(wr_valid_i)
                   - capture_pkg::credit_t'(pop_ok);

            credit_ret_o <= pop_ok;   // one credit back per freed entry
        end
    end

endmodule
